/* verilog.f */
+incdir+sim
design/tag_buff_pkg.sv
design/tag_frame_writer.sv
design/ebi_read_port.sv
design/word_fifo.sv
design/tag_data_buff.sv
sim/tb_tag_data_buff.sv

/* Makefile */
# tag data buffer simulation and lint with Verilator

VERILATOR  ?= verilator
TOP        := tb_tag_data_buff
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: run build lint clean

# build, then run; a $fatal in the testbench gives a failing exit status
run: build
	./$(OBJ_DIR)/V$(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_tag_checks.svh */
// tag buffer testbench checks: frame reference model and typed compare tasks
`ifndef TB_TAG_CHECKS_SVH
`define TB_TAG_CHECKS_SVH

typedef logic [tag_buff_pkg::DATA_WIDTH-1:0] beat_t;
typedef beat_t beat_q_t[$];
typedef tag_buff_pkg::read_slice_t slice_q_t[$];

////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////

// expected readout of one frame
// every beat low slice first, then the tag record
function automatic slice_q_t expand_frame(input beat_q_t beats,
                                          input tag_buff_pkg::tag_mask_t mask);
  tag_buff_pkg::stored_word_u word;
  beat_t flat;
  slice_q_t slices;
  foreach (beats[b]) begin
    // data view, channel 0 in the low bits
    word.data = beats[b];
    flat = word;
    for (int s = 0; s < tag_buff_pkg::SLICES_PER_WORD; s++) begin
      slices.push_back(flat[s*tag_buff_pkg::READ_WIDTH +: tag_buff_pkg::READ_WIDTH]);
    end
  end
  // tag view, mask zero extended into slice 0
  word.tag.pad  = '0;
  word.tag.mask = mask;
  flat = word;
  for (int s = 0; s < tag_buff_pkg::SLICES_PER_WORD; s++) begin
    slices.push_back(flat[s*tag_buff_pkg::READ_WIDTH +: tag_buff_pkg::READ_WIDTH]);
  end
  return slices;
endfunction

////////////////////////////////////////////////////////////
// compares
////////////////////////////////////////////////////////////

task automatic check_slice(input string what, input tag_buff_pkg::read_slice_t exp,
                           input tag_buff_pkg::read_slice_t act);
  if (act !== exp) begin
    $display("ERROR %s, %s: expected %h, actual %h", test_name, what, exp, act);
    fail_stop();
  end
endtask

task automatic check_flag(input string what, input bit exp, input bit act);
  if (act !== exp) begin
    $display("ERROR %s, %s: expected %0b, actual %0b", test_name, what, exp, act);
    fail_stop();
  end
endtask

`endif

/* sim/tb_tag_data_buff.sv */
// tag data buffer testbench: framed stream in, strobed 16 bit readout checked against a model
`timescale 1ns/1ps

module tb_tag_data_buff;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int RAND_SEED = 11695;
  // queue limit that leaves room in the fifo for a six word frame
  localparam int ROOM_SLICES = tag_buff_pkg::SLICES_PER_WORD * (tag_buff_pkg::FIFO_DEPTH - 8);
  // back pressure fill uses four beat frames, five words each
  localparam int BP_BEATS = 4;
  localparam int BP_WORDS = BP_BEATS + 1;

  logic                                clk = 1'b0;
  logic                                rst_n;
  logic                                s_axis_tvalid;
  logic                                s_axis_tready;
  logic [tag_buff_pkg::DATA_WIDTH-1:0] s_axis_tdata;
  tag_buff_pkg::tag_mask_t             s_axis_tuser;
  logic                                s_axis_tlast;
  logic                                rd_ena;
  logic                                rd_ready;
  tag_buff_pkg::read_slice_t           rd_data;

  // strobe from the reader process or from the main sequence
  logic  auto_ena;
  logic  manual_ena;
  bit    reader_on;
  string test_name;

  task automatic fail_stop();
    $display("Verification failed");
    $fatal(1, "run stopped at first failure");
  endtask

  `include "tb_tag_checks.svh"

  // slices still to be read back, oldest first
  slice_q_t exp_q;

  assign rd_ena = auto_ena | manual_ena;

  tag_data_buff i_tag_data_buff (
    .clk           (clk),
    .rst_n         (rst_n),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tlast  (s_axis_tlast),
    .rd_ena        (rd_ena),
    .rd_ready      (rd_ready),
    .rd_data       (rd_data)
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // inputs move 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic tick_or_timeout(inout int waited, input string what);
    next_cycle();
    waited++;
    if (waited > TIMEOUT_CYCLES) begin
      $display("timeout while waiting: %s", what);
      fail_stop();
    end
  endtask

  function automatic beat_t random_beat();
    return {$urandom(), $urandom()};
  endfunction

  task automatic queue_frame(input beat_q_t beats, input tag_buff_pkg::tag_mask_t mask);
    slice_q_t slices;
    slices = expand_frame(beats, mask);
    foreach (slices[i]) begin
      exp_q.push_back(slices[i]);
    end
  endtask

  // tready only depends on registers, so it is settled 1 ns after the edge
  task automatic send_beat(input beat_t data, input tag_buff_pkg::tag_mask_t user,
                           input logic last);
    int waited;
    waited = 0;
    s_axis_tvalid = 1'b1;
    s_axis_tdata  = data;
    s_axis_tuser  = user;
    s_axis_tlast  = last;
    while (!s_axis_tready) begin
      tick_or_timeout(waited, "stream beat accepted");
    end
    next_cycle();
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
  endtask

  task automatic send_frame(input int nbeats, input int max_gap, input bit check_tready);
    beat_q_t beats;
    tag_buff_pkg::tag_mask_t mask;
    mask = tag_buff_pkg::tag_mask_t'($urandom());
    for (int b = 0; b < nbeats; b++) begin
      beats.push_back(random_beat());
    end
    queue_frame(beats, mask);
    foreach (beats[b]) begin
      repeat ($urandom_range(0, max_gap)) next_cycle();
      send_beat(beats[b], mask, b == nbeats - 1);
    end
    if (check_tready) begin
      // stalled for the tag record cycle only
      check_flag("tready after tlast", 1'b0, s_axis_tready);
      next_cycle();
      check_flag("tready after tag word", 1'b1, s_axis_tready);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || rd_ready) begin
      tick_or_timeout(waited, "buffer drained");
    end
  endtask

  task automatic wait_room();
    int waited;
    waited = 0;
    while (exp_q.size() > ROOM_SLICES) begin
      tick_or_timeout(waited, "room for next frame");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reader, one strobe per slice
  ////////////////////////////////////////////////////////////

  always begin : reader
    int gap;
    tag_buff_pkg::read_slice_t exp;
    next_cycle();
    if (reader_on && rd_ready) begin
      auto_ena = 1'b1;
      // new slice registered on this edge
      next_cycle();
      auto_ena = 1'b0;
      if (exp_q.size() == 0) begin
        $display("a slice was read back with nothing left to expect");
        fail_stop();
      end else begin
        exp = exp_q.pop_front();
        check_slice("read back", exp, rd_data);
      end
      gap = $urandom_range(1, 3);
      repeat (gap - 1) @(posedge clk);
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    tag_buff_pkg::tag_mask_t   mask;
    tag_buff_pkg::read_slice_t exp;
    beat_q_t                   beats;
    int                        lead;
    int                        waited;
    void'($urandom(RAND_SEED));
    rst_n         = 1'b0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tuser  = '0;
    s_axis_tlast  = 1'b0;
    auto_ena      = 1'b0;
    manual_ena    = 1'b0;
    reader_on     = 1'b0;

    test_name = "reset";
    repeat (4) @(posedge clk);
    #1;
    check_flag("tready in reset", 1'b0, s_axis_tready);
    check_flag("rd_ready in reset", 1'b0, rd_ready);
    rst_n = 1'b1;
    next_cycle();
    check_flag("tready after release", 1'b1, s_axis_tready);
    // strobe with nothing stored is ignored
    manual_ena = 1'b1;
    next_cycle();
    manual_ena = 1'b0;
    repeat (3) next_cycle();
    check_flag("rd_ready after empty strobe", 1'b0, rd_ready);
    check_slice("rd_data after empty strobe", '0, rd_data);

    test_name = "single frames";
    reader_on = 1'b1;
    send_frame(1, 0, 1'b1);
    send_frame(4, 0, 1'b1);
    wait_drain();

    test_name = "back to back";
    for (int f = 0; f < 12; f++) begin
      wait_room();
      send_frame($urandom_range(1, 5), 2, 1'b1);
    end
    wait_drain();

    test_name = "back pressure";
    reader_on = 1'b0;
    for (int f = 0; f < (tag_buff_pkg::FIFO_DEPTH - 1) / BP_WORDS; f++) begin
      send_frame(BP_BEATS, 0, 1'b1);
    end
    // head of one more frame tops the fifo up to its depth
    lead = tag_buff_pkg::FIFO_DEPTH - BP_WORDS * ((tag_buff_pkg::FIFO_DEPTH - 1) / BP_WORDS);
    mask = tag_buff_pkg::tag_mask_t'($urandom());
    beats = {};
    for (int b = 0; b <= lead; b++) begin
      beats.push_back(random_beat());
    end
    queue_frame(beats, mask);
    for (int b = 0; b < lead; b++) begin
      send_beat(beats[b], mask, 1'b0);
    end
    s_axis_tvalid = 1'b1;
    s_axis_tdata  = beats[lead];
    s_axis_tuser  = mask;
    s_axis_tlast  = 1'b1;
    repeat (4) begin
      check_flag("tready while full", 1'b0, s_axis_tready);
      check_flag("rd_ready while full", 1'b1, rd_ready);
      next_cycle();
    end
    reader_on = 1'b1;
    send_beat(beats[lead], mask, 1'b1);
    wait_drain();

    test_name = "level strobe";
    reader_on = 1'b0;
    mask = tag_buff_pkg::tag_mask_t'($urandom());
    // distinct slices, so an extra take shows up
    beats = {};
    beats.push_back(64'h4444_3333_2222_1111);
    queue_frame(beats, mask);
    send_beat(beats[0], mask, 1'b1);
    waited = 0;
    while (!rd_ready) begin
      tick_or_timeout(waited, "rd_ready for level strobe");
    end
    manual_ena = 1'b1;
    next_cycle();
    exp = exp_q.pop_front();
    check_slice("first slice", exp, rd_data);
    repeat (4) begin
      next_cycle();
      check_slice("strobe held high", exp, rd_data);
    end
    manual_ena = 1'b0;
    next_cycle();
    check_slice("strobe released", exp, rd_data);
    manual_ena = 1'b1;
    next_cycle();
    manual_ena = 1'b0;
    exp = exp_q.pop_front();
    check_slice("next rising edge", exp, rd_data);
    // strobe low for one edge before the reader takes over
    next_cycle();
    reader_on = 1'b1;

    test_name = "drain";
    wait_drain();
    repeat (4) next_cycle();
    check_flag("rd_ready after drain", 1'b0, rd_ready);
    if (exp_q.size() != 0) begin
      $display("%0d expected slices were never read back", exp_q.size());
      fail_stop();
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

/* design/tag_data_buff.sv */
// tag data buffer top: frame stream in, 16 bit processor readout out
`timescale 1ns/1ps

module tag_data_buff (
  input  logic                                clk,
  input  logic                                rst_n,
  // stream slave side
  input  logic                                s_axis_tvalid,
  output logic                                s_axis_tready,
  input  logic [tag_buff_pkg::DATA_WIDTH-1:0] s_axis_tdata,
  input  tag_buff_pkg::tag_mask_t             s_axis_tuser,
  input  logic                                s_axis_tlast,
  // processor side
  input  logic                                rd_ena,
  output logic                                rd_ready,
  output tag_buff_pkg::read_slice_t           rd_data
);

  // writer to fifo
  logic                                     wr_valid;
  tag_buff_pkg::stored_word_u               wr_word;
  logic                                     full;
  // read port to fifo
  logic                                     rd_take;
  logic                                     rd_pop;
  logic [tag_buff_pkg::SLICE_IDX_WIDTH-1:0] rd_slice;
  logic                                     empty;

  ////////////////////////////////////////////////////////////
  // stream side
  ////////////////////////////////////////////////////////////

  tag_frame_writer i_tag_frame_writer (
    .clk           (clk),
    .rst_n         (rst_n),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tlast  (s_axis_tlast),
    .full          (full),
    .wr_valid      (wr_valid),
    .wr_word       (wr_word)
  );

  ////////////////////////////////////////////////////////////
  // processor side
  ////////////////////////////////////////////////////////////

  ebi_read_port i_ebi_read_port (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_ena   (rd_ena),
    .empty    (empty),
    .rd_take  (rd_take),
    .rd_pop   (rd_pop),
    .rd_slice (rd_slice)
  );

  // at least one unread word
  assign rd_ready = ~empty;

  ////////////////////////////////////////////////////////////
  // shared store
  ////////////////////////////////////////////////////////////

  word_fifo i_word_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_valid (wr_valid),
    .wr_word  (wr_word),
    .full     (full),
    .rd_take  (rd_take),
    .rd_pop   (rd_pop),
    .rd_slice (rd_slice),
    .empty    (empty),
    .rd_data  (rd_data)
  );

endmodule

/* design/word_fifo.sv */
// word fifo: register array of wide words, read back one slice at a time
`timescale 1ns/1ps

module word_fifo (
  input  logic                                     clk,
  input  logic                                     rst_n,
  // write side, writer only drives wr_valid with room
  input  logic                                     wr_valid,
  input  tag_buff_pkg::stored_word_u               wr_word,
  output logic                                     full,
  // read side, slice take and word pop
  input  logic                                     rd_take,
  input  logic                                     rd_pop,
  input  logic [tag_buff_pkg::SLICE_IDX_WIDTH-1:0] rd_slice,
  output logic                                     empty,
  output tag_buff_pkg::read_slice_t                rd_data
);

  // storage
  tag_buff_pkg::stored_word_u mem [tag_buff_pkg::FIFO_DEPTH];

  // pointers with wrap bit on top
  logic [tag_buff_pkg::PTR_WIDTH-1:0] wr_ptr;
  logic [tag_buff_pkg::PTR_WIDTH-1:0] rd_ptr;
  // array addresses without the wrap bit
  logic [tag_buff_pkg::PTR_WIDTH-2:0] wr_addr;
  logic [tag_buff_pkg::PTR_WIDTH-2:0] rd_addr;
  // wrap bits differ
  logic                               wrapped;
  // words held, modulo pointer range
  logic [tag_buff_pkg::PTR_WIDTH-1:0] level;

  // head word cut into processor slices
  tag_buff_pkg::read_slice_t [tag_buff_pkg::SLICES_PER_WORD-1:0] head_slices;

  ////////////////////////////////////////////////////////////
  // status
  ////////////////////////////////////////////////////////////

  assign wr_addr = wr_ptr[tag_buff_pkg::PTR_WIDTH-2:0];
  assign rd_addr = rd_ptr[tag_buff_pkg::PTR_WIDTH-2:0];
  assign wrapped =
    wr_ptr[tag_buff_pkg::PTR_WIDTH-1] ^ rd_ptr[tag_buff_pkg::PTR_WIDTH-1];

  // same address, wrap bit tells full from empty
  assign empty = ~wrapped & (wr_addr == rd_addr);
  assign full  = wrapped & (wr_addr == rd_addr);

  assign level = wr_ptr - rd_ptr;

  ////////////////////////////////////////////////////////////
  // pointers
  ////////////////////////////////////////////////////////////

  // write and pop may land on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (wr_valid) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (rd_pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // storage and read slice
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_word;
    end
  end

  // slice 0 is the low 16 bits
  assign head_slices = mem[rd_addr];

  // registered slice, held until the next take
  // head is read before a same-edge pop moves rd_ptr
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (rd_take) begin
      rd_data <= head_slices[rd_slice];
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // writer must hold off on a full fifo
  a_no_write_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_valid |-> !full
  );

  // a take always reads a stored word, never stale array contents
  a_take_has_word: assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_take |-> (level != '0)
  );

  // occupancy never beyond the array size
  a_level_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    level <= tag_buff_pkg::PTR_WIDTH'(tag_buff_pkg::FIFO_DEPTH)
  );

endmodule

/* design/ebi_read_port.sv */
// ebi read port: rd_ena edge detect, slice sequencing and underflow guard
`timescale 1ns/1ps

module ebi_read_port (
  input  logic                                     clk,
  input  logic                                     rst_n,
  // processor strobe, level
  input  logic                                     rd_ena,
  // fifo status and read controls
  input  logic                                     empty,
  output logic                                     rd_take,
  output logic                                     rd_pop,
  output logic [tag_buff_pkg::SLICE_IDX_WIDTH-1:0] rd_slice
);

  // strobe from the previous cycle
  logic rd_ena_d;
  // rising edge of the strobe
  logic rd_edge;
  // current slice is the top one of the word
  logic last_slice;

  ////////////////////////////////////////////////////////////
  // strobe edge
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ena_d <= 1'b0;
    end else begin
      rd_ena_d <= rd_ena;
    end
  end

  assign rd_edge = rd_ena & ~rd_ena_d;

  // edge on an empty fifo is dropped
  assign rd_take = rd_edge & ~empty;

  ////////////////////////////////////////////////////////////
  // slice sequencer
  ////////////////////////////////////////////////////////////

  assign last_slice =
    (rd_slice == tag_buff_pkg::SLICE_IDX_WIDTH'(tag_buff_pkg::SLICES_PER_WORD - 1));

  // word leaves the fifo with its last slice
  assign rd_pop = rd_take & last_slice;

  // low slice first, back to zero after each pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_slice <= '0;
    end else if (rd_pop) begin
      rd_slice <= '0;
    end else if (rd_take) begin
      rd_slice <= rd_slice + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // a pop on an empty fifo would corrupt the pointers
  a_no_pop_when_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(rd_pop) |-> !empty
  );

endmodule

/* design/tag_frame_writer.sv */
// tag frame writer: stream slave storing sample beats and appending a tag record per frame
`timescale 1ns/1ps

module tag_frame_writer (
  input  logic                                clk,
  input  logic                                rst_n,
  // stream slave side
  input  logic                                s_axis_tvalid,
  output logic                                s_axis_tready,
  input  logic [tag_buff_pkg::DATA_WIDTH-1:0] s_axis_tdata,
  input  tag_buff_pkg::tag_mask_t             s_axis_tuser,
  input  logic                                s_axis_tlast,
  // fifo write side
  input  logic                                full,
  output logic                                wr_valid,
  output tag_buff_pkg::stored_word_u          wr_word
);

  // high from the first edge after reset release
  logic                    run;
  // tag record owed for the frame just closed
  logic                    tag_pending;
  // tuser of the last beat
  tag_buff_pkg::tag_mask_t tag_mask;
  // handshake and write qualifiers
  logic                    beat_acc;
  logic                    tag_write;

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  // stall while a tag record waits or the fifo has no room
  assign s_axis_tready = run & ~tag_pending & ~full;
  assign beat_acc = s_axis_tvalid & s_axis_tready;

  // tag record goes out on the first cycle with room
  assign tag_write = tag_pending & ~full;

  // beat and tag record never compete, tready is low while pending
  assign wr_valid = beat_acc | tag_write;

  ////////////////////////////////////////////////////////////
  // tag record state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag_pending <= 1'b0;
    end else if (beat_acc && s_axis_tlast) begin
      tag_pending <= 1'b1;
    end else if (tag_write) begin
      tag_pending <= 1'b0;
    end
  end

  // mask captured on the accepting tlast edge
  always_ff @(posedge clk) begin
    if (beat_acc && s_axis_tlast) begin
      tag_mask <= s_axis_tuser;
    end
  end

  ////////////////////////////////////////////////////////////
  // word mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    wr_word = '0;
    if (tag_pending) begin
      // tag view, mask in the low bits
      wr_word.tag.pad  = '0;
      wr_word.tag.mask = tag_mask;
    end else begin
      // data view, one sample per channel
      for (int ch = 0; ch < tag_buff_pkg::NUM_CHANNELS; ch++) begin
        wr_word.data[ch] =
          s_axis_tdata[ch*tag_buff_pkg::CHANNEL_WIDTH +: tag_buff_pkg::CHANNEL_WIDTH];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // full comes back from the fifo, never write into it
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_valid |-> !full
  );

  // a closed frame blocks new beats until its tag record is written
  a_no_beat_while_pending: assert property (
    @(posedge clk) disable iff (!rst_n)
    tag_pending |-> !beat_acc
  );

endmodule

/* design/tag_buff_pkg.sv */
// tag buffer package: sizes, sample and slice types, stored word layout
package tag_buff_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  // one bit per detectable tag
  localparam int NUM_TAGS = 10;
  // samples per stream beat and bits per sample
  localparam int NUM_CHANNELS = 4;
  localparam int CHANNEL_WIDTH = 16;
  // one stored word is one full stream beat
  localparam int DATA_WIDTH = NUM_CHANNELS * CHANNEL_WIDTH;
  // processor bus width, low slice read first
  localparam int READ_WIDTH = 16;
  localparam int SLICES_PER_WORD = DATA_WIDTH / READ_WIDTH;
  localparam int SLICE_IDX_WIDTH = $clog2(SLICES_PER_WORD);
  // fifo depth, power of two only
  localparam int FIFO_DEPTH = 16;
  // address bits plus one wrap bit
  localparam int PTR_WIDTH = $clog2(FIFO_DEPTH) + 1;
  // zero fill above the tag mask in a tag record
  localparam int PAD_WIDTH = DATA_WIDTH - NUM_TAGS;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic [NUM_TAGS-1:0] tag_mask_t;
  typedef logic [CHANNEL_WIDTH-1:0] sample_t;
  typedef logic [READ_WIDTH-1:0] read_slice_t;

  // one fifo word, seen either as samples or as a tag record
  // channel 0 sits in the low bits
  typedef union packed {
    sample_t [NUM_CHANNELS-1:0] data;
    struct packed {
      // always zero in a written tag record
      logic [PAD_WIDTH-1:0] pad;
      tag_mask_t            mask;
    } tag;
  } stored_word_u;

endpackage
